// File: build.f
logic/io_plane_pkg.sv
logic/tick_gen.sv
logic/cdtimer16.sv
logic/event_controller.sv
logic/usage_counter.sv
logic/mem_bridge.sv
logic/register_plane.sv
logic/io_plane.sv
testbench/bus_slave_model.sv
testbench/io_plane_tb.sv

// File: logic/cdtimer16.sv
`timescale 1ns/1ns
`default_nettype none

module cdtimer16 (
    input  logic                            sysclk,
    input  logic                            rst,
    input  logic [io_plane_pkg::DATA_W-1:0] load_data,
    input  logic                            load,
    input  logic                            tick,
    output logic [io_plane_pkg::DATA_W-1:0] count,
    output logic                            expired
);

    // a zero count means the timer has run out.
    assign expired = (count == '0);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            // a load wins over a tick in the same cycle.
            count <= load_data;
        end else if (tick && !expired) begin
            count <= count - 1'b1;
        end
    end

    // once expired, the timer stays at zero until the core reloads it.
    count_no_wrap: assert property (
        @(posedge sysclk) disable iff (rst)
        (expired && !load) |=> expired
    ) else $error("cdtimer16 count wrapped below zero");

endmodule

`default_nettype wire

// File: logic/event_controller.sv
`timescale 1ns/1ns
`default_nettype none

module event_controller (
    input  logic                                sysclk,
    input  logic                                rst,
    input  logic [io_plane_pkg::DATA_W-1:0]     mask_data,
    input  logic                                mask_load,
    input  logic [io_plane_pkg::NUM_EVENTS-1:0] event_lines,
    output logic [io_plane_pkg::DATA_W-1:0]     event_priority
);
    import io_plane_pkg::*;

    logic [NUM_EVENTS-1:0] mask;
    logic [NUM_EVENTS-1:0] pending;

    // rst here also carries the soft reset from the top level.
    always_ff @(posedge sysclk) begin
        if (rst) begin
            mask <= '0;
        end else if (mask_load) begin
            mask <= mask_data[NUM_EVENTS-1:0];
        end
    end

    // only enabled lines can be pending.
    assign pending = event_lines & mask;

    // scan from the least urgent line down.
    // the last hit is the lowest index and so the most urgent.
    always_comb begin
        event_priority = NO_EVENT;
        for (int i = NUM_EVENTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                event_priority = DATA_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/io_plane.sv
`timescale 1ns/1ns
`default_nettype none

module io_plane (
    input  logic                              sysclk,
    input  logic                              rst,
    input  io_plane_pkg::reg_addr_t           reg_addr,
    input  logic                              reg_load,
    input  logic                              reg_read,
    input  logic [io_plane_pkg::DATA_W-1:0]   load_data,
    output logic [io_plane_pkg::DATA_W-1:0]   read_data,
    output logic                              mcu_wait,
    input  logic [1:0]                        key,
    output logic [7:0]                        led,
    output logic [3:0]                        anmux_ctrl,
    output logic [1:0]                        scope,
    output logic [2*io_plane_pkg::DATA_W-1:0] m0_address,
    output logic                              m0_read,
    output logic                              m0_write,
    output logic [io_plane_pkg::DATA_W-1:0]   m0_writedata,
    input  logic [io_plane_pkg::DATA_W-1:0]   m0_readdata,
    input  logic                              m0_waitrequest
);
    import io_plane_pkg::*;

    logic pulse_us, pulse_ms;
    logic ustimer0_load, mstimer0_load, mstimer1_load;
    logic ustimer0_expired, mstimer0_expired, mstimer1_expired;
    logic usage_clear, mask_load, priority_read;
    logic ad_hi_load, ad_lo_load, wdata_load, wdata_read;
    logic [DATA_W-1:0] ustimer0, mstimer0, mstimer1;
    logic [DATA_W-1:0] usage, event_priority, soft_event;
    logic [DATA_W-1:0] ad_hi, ad_lo, rdata;
    logic [NUM_EVENTS-1:0] event_lines;

    tick_gen ticks (
        .sysclk(sysclk), .rst(rst), .pulse_us(pulse_us), .pulse_ms(pulse_ms)
    );

    // one microsecond timer, two millisecond timers.
    cdtimer16 ustimer0_inst (
        .sysclk(sysclk), .rst(rst), .load_data(load_data), .load(ustimer0_load),
        .tick(pulse_us), .count(ustimer0), .expired(ustimer0_expired)
    );
    cdtimer16 mstimer0_inst (
        .sysclk(sysclk), .rst(rst), .load_data(load_data), .load(mstimer0_load),
        .tick(pulse_ms), .count(mstimer0), .expired(mstimer0_expired)
    );
    cdtimer16 mstimer1_inst (
        .sysclk(sysclk), .rst(rst), .load_data(load_data), .load(mstimer1_load),
        .tick(pulse_ms), .count(mstimer1), .expired(mstimer1_expired)
    );

    // event lines in priority order; keys are active low.
    assign event_lines[EV_USTIMER0] = ustimer0_expired;
    assign event_lines[EV_MSTIMER0] = mstimer0_expired;
    assign event_lines[EV_MSTIMER1] = mstimer1_expired;
    assign event_lines[EV_KEY0] = !key[0];
    assign event_lines[EV_KEY1] = !key[1];
    assign event_lines[EV_SOFT0] = soft_event[0];
    assign event_lines[EV_SOFT1] = soft_event[1];
    assign event_lines[EV_SOFT2] = soft_event[2];
    assign event_lines[EV_SOFT3] = soft_event[3];

    // the program can clear the mask through the soft-event register.
    event_controller events (
        .sysclk(sysclk), .rst(rst || soft_event[EVENT_RESET_BIT]),
        .mask_data(load_data), .mask_load(mask_load),
        .event_lines(event_lines), .event_priority(event_priority)
    );

    // each poll of the priority register counts as one idle loop.
    usage_counter usage_inst (
        .sysclk(sysclk), .rst(rst), .poll(priority_read),
        .window_end(pulse_ms), .clear(usage_clear), .usage(usage)
    );

    mem_bridge bridge (
        .sysclk(sysclk), .rst(rst), .load_data(load_data),
        .ad_hi_load(ad_hi_load), .ad_lo_load(ad_lo_load),
        .wdata_load(wdata_load), .wdata_read(wdata_read),
        .ad_hi(ad_hi), .ad_lo(ad_lo), .read_data_reg(rdata), .mcu_wait(mcu_wait),
        .m0_address(m0_address), .m0_read(m0_read), .m0_write(m0_write),
        .m0_writedata(m0_writedata), .m0_readdata(m0_readdata),
        .m0_waitrequest(m0_waitrequest)
    );

    register_plane regs (
        .sysclk(sysclk), .rst(rst), .reg_addr(reg_addr), .reg_load(reg_load),
        .reg_read(reg_read), .load_data(load_data), .read_data(read_data),
        .key(key), .led(led), .anmux_ctrl(anmux_ctrl), .soft_event(soft_event),
        .ustimer0_load(ustimer0_load), .mstimer0_load(mstimer0_load),
        .mstimer1_load(mstimer1_load), .usage_clear(usage_clear),
        .mask_load(mask_load), .priority_read(priority_read),
        .ad_hi_load(ad_hi_load), .ad_lo_load(ad_lo_load),
        .wdata_load(wdata_load), .wdata_read(wdata_read),
        .ustimer0(ustimer0), .mstimer0(mstimer0), .mstimer1(mstimer1),
        .usage(usage), .event_priority(event_priority), .ad_hi(ad_hi),
        .ad_lo(ad_lo), .wdata(m0_writedata), .rdata(rdata)
    );

    // two soft-event bits go to the scope pins for timing checks.
    assign scope = soft_event[14:13];

endmodule

`default_nettype wire

// File: logic/io_plane_pkg.sv
`default_nettype none

package io_plane_pkg;

    // width of every peripheral register.
    localparam int DATA_W = 16;

    // register numbers as the core sees them.
    typedef enum logic [4:0] {
        REG_LEDS           = 5'd0,
        REG_KEYS           = 5'd1,
        REG_ANMUX          = 5'd2,
        REG_SOFT_EVENT     = 5'd3,
        REG_USTIMER0       = 5'd4,
        REG_MSTIMER0       = 5'd5,
        REG_MSTIMER1       = 5'd6,
        REG_USAGE          = 5'd7,
        REG_EVENT_PRIORITY = 5'd8,
        REG_AV_AD_HI       = 5'd9,
        REG_AV_AD_LO       = 5'd10,
        REG_AV_WRITE_DATA  = 5'd11,
        REG_AV_READ_DATA   = 5'd12
    } reg_addr_t;

    // memory bus bridge states.
    typedef enum logic [1:0] {
        BR_IDLE,
        BR_WRITE,
        BR_READ,
        BR_CAPTURE
    } bridge_state_t;

    // sysclk cycles per microsecond, microseconds per millisecond.
    localparam int CYCLES_PER_US = 50;
    localparam int US_PER_MS = 1000;
    localparam int US_CNT_W = $clog2(CYCLES_PER_US);
    localparam int MS_CNT_W = $clog2(US_PER_MS);
    localparam logic [US_CNT_W-1:0] US_LAST = US_CNT_W'(CYCLES_PER_US - 1);
    localparam logic [MS_CNT_W-1:0] MS_LAST = MS_CNT_W'(US_PER_MS - 1);

    // event lines, most urgent first.
    localparam int NUM_EVENTS = 9;
    localparam int EV_USTIMER0 = 0;
    localparam int EV_MSTIMER0 = 1;
    localparam int EV_MSTIMER1 = 2;
    localparam int EV_KEY0 = 3;
    localparam int EV_KEY1 = 4;
    localparam int EV_SOFT0 = 5;
    localparam int EV_SOFT1 = 6;
    localparam int EV_SOFT2 = 7;
    localparam int EV_SOFT3 = 8;

    // priority value when nothing is pending.
    localparam logic [DATA_W-1:0] NO_EVENT = '1;
    // soft-event bit that clears the event mask.
    localparam int EVENT_RESET_BIT = 15;

endpackage

`default_nettype wire

// File: logic/mem_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module mem_bridge (
    input  logic                              sysclk,
    input  logic                              rst,
    input  logic [io_plane_pkg::DATA_W-1:0]   load_data,
    input  logic                              ad_hi_load,
    input  logic                              ad_lo_load,
    input  logic                              wdata_load,
    input  logic                              wdata_read,
    output logic [io_plane_pkg::DATA_W-1:0]   ad_hi,
    output logic [io_plane_pkg::DATA_W-1:0]   ad_lo,
    output logic [io_plane_pkg::DATA_W-1:0]   read_data_reg,
    output logic                              mcu_wait,
    output logic [2*io_plane_pkg::DATA_W-1:0] m0_address,
    output logic                              m0_read,
    output logic                              m0_write,
    output logic [io_plane_pkg::DATA_W-1:0]   m0_writedata,
    input  logic [io_plane_pkg::DATA_W-1:0]   m0_readdata,
    input  logic                              m0_waitrequest
);
    import io_plane_pkg::*;

    bridge_state_t state;
    bridge_state_t state_next;
    logic          accepted;

    // the slave takes the command in the first cycle without waitrequest.
    assign accepted = (m0_read || m0_write) && !m0_waitrequest;

    always_comb begin
        state_next = state;
        case (state)
            BR_IDLE: begin
                // loading write data starts a write, reading it starts a read.
                if (wdata_load) begin
                    state_next = BR_WRITE;
                end else if (wdata_read) begin
                    state_next = BR_READ;
                end
            end
            BR_WRITE: if (accepted) state_next = BR_IDLE;
            BR_READ: if (accepted) state_next = BR_CAPTURE;
            // one more cycle so the captured word is settled when the core resumes.
            BR_CAPTURE: state_next = BR_IDLE;
            default: state_next = BR_IDLE;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (rst) begin
            state <= BR_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // address and data registers.
    always_ff @(posedge sysclk) begin
        if (ad_hi_load) ad_hi <= load_data;
        if (ad_lo_load) ad_lo <= load_data;
        if (wdata_load) m0_writedata <= load_data;
        // readdata is valid on acceptance, so it lands in the register for BR_CAPTURE.
        if (state == BR_READ && accepted) read_data_reg <= m0_readdata;
    end

    assign m0_address = {ad_hi, ad_lo};
    assign m0_write = (state == BR_WRITE);
    assign m0_read = (state == BR_READ);
    // the core stalls for the whole transaction.
    assign mcu_wait = (state != BR_IDLE);

    // the core must hold off new triggers while it is stalled.
    no_trigger_when_busy: assert property (
        @(posedge sysclk) disable iff (rst)
        (wdata_load || wdata_read) |-> (state == BR_IDLE)
    ) else $error("bridge triggered while a transaction is running");

endmodule

`default_nettype wire

// File: logic/register_plane.sv
`timescale 1ns/1ns
`default_nettype none

module register_plane (
    input  logic                            sysclk,
    input  logic                            rst,
    input  io_plane_pkg::reg_addr_t         reg_addr,
    input  logic                            reg_load,
    input  logic                            reg_read,
    input  logic [io_plane_pkg::DATA_W-1:0] load_data,
    output logic [io_plane_pkg::DATA_W-1:0] read_data,
    input  logic [1:0]                      key,
    output logic [7:0]                      led,
    output logic [3:0]                      anmux_ctrl,
    output logic [io_plane_pkg::DATA_W-1:0] soft_event,
    output logic                            ustimer0_load,
    output logic                            mstimer0_load,
    output logic                            mstimer1_load,
    output logic                            usage_clear,
    output logic                            mask_load,
    output logic                            priority_read,
    output logic                            ad_hi_load,
    output logic                            ad_lo_load,
    output logic                            wdata_load,
    output logic                            wdata_read,
    input  logic [io_plane_pkg::DATA_W-1:0] ustimer0,
    input  logic [io_plane_pkg::DATA_W-1:0] mstimer0,
    input  logic [io_plane_pkg::DATA_W-1:0] mstimer1,
    input  logic [io_plane_pkg::DATA_W-1:0] usage,
    input  logic [io_plane_pkg::DATA_W-1:0] event_priority,
    input  logic [io_plane_pkg::DATA_W-1:0] ad_hi,
    input  logic [io_plane_pkg::DATA_W-1:0] ad_lo,
    input  logic [io_plane_pkg::DATA_W-1:0] wdata,
    input  logic [io_plane_pkg::DATA_W-1:0] rdata
);
    import io_plane_pkg::*;

    // load strobes for the blocks behind the plane.
    assign ustimer0_load = reg_load && (reg_addr == REG_USTIMER0);
    assign mstimer0_load = reg_load && (reg_addr == REG_MSTIMER0);
    assign mstimer1_load = reg_load && (reg_addr == REG_MSTIMER1);
    assign usage_clear = reg_load && (reg_addr == REG_USAGE);
    // writing the priority register sets the event mask.
    assign mask_load = reg_load && (reg_addr == REG_EVENT_PRIORITY);
    assign ad_hi_load = reg_load && (reg_addr == REG_AV_AD_HI);
    assign ad_lo_load = reg_load && (reg_addr == REG_AV_AD_LO);
    assign wdata_load = reg_load && (reg_addr == REG_AV_WRITE_DATA);
    // read strobes only carry side effects.
    assign priority_read = reg_read && (reg_addr == REG_EVENT_PRIORITY);
    assign wdata_read = reg_read && (reg_addr == REG_AV_WRITE_DATA);

    // local output registers.
    always_ff @(posedge sysclk) begin
        if (rst) begin
            led <= '0;
            anmux_ctrl <= '0;
            soft_event <= '0;
        end else if (reg_load) begin
            case (reg_addr)
                REG_LEDS: led <= load_data[7:0];
                REG_ANMUX: anmux_ctrl <= load_data[3:0];
                REG_SOFT_EVENT: soft_event <= load_data;
                default: ;
            endcase
        end
    end

    // read data follows the address combinationally.
    always_comb begin
        case (reg_addr)
            REG_LEDS: read_data = {8'h00, led};
            REG_KEYS: read_data = {14'h0000, key};
            REG_ANMUX: read_data = {12'h000, anmux_ctrl};
            REG_SOFT_EVENT: read_data = soft_event;
            REG_USTIMER0: read_data = ustimer0;
            REG_MSTIMER0: read_data = mstimer0;
            REG_MSTIMER1: read_data = mstimer1;
            REG_USAGE: read_data = usage;
            REG_EVENT_PRIORITY: read_data = event_priority;
            REG_AV_AD_HI: read_data = ad_hi;
            REG_AV_AD_LO: read_data = ad_lo;
            REG_AV_WRITE_DATA: read_data = wdata;
            REG_AV_READ_DATA: read_data = rdata;
            default: read_data = '0;
        endcase
    end

    // the core issues one access per cycle.
    one_access_per_cycle: assert property (
        @(posedge sysclk) disable iff (rst)
        !(reg_load && reg_read)
    ) else $error("register load and read strobes high together");

endmodule

`default_nettype wire

// File: logic/tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tick_gen (
    input  logic sysclk,
    input  logic rst,
    output logic pulse_us,
    output logic pulse_ms
);
    import io_plane_pkg::*;

    logic [US_CNT_W-1:0] us_count;
    logic [MS_CNT_W-1:0] ms_count;

    // one pulse on the last cycle of each microsecond.
    assign pulse_us = (us_count == US_LAST);
    // every thousandth microsecond pulse is also a millisecond pulse.
    assign pulse_ms = pulse_us && (ms_count == MS_LAST);

    always_ff @(posedge sysclk) begin
        if (rst) begin
            us_count <= '0;
            ms_count <= '0;
        end else begin
            if (pulse_us) begin
                us_count <= '0;
            end else begin
                us_count <= us_count + 1'b1;
            end
            // millisecond counter only moves on microsecond ticks.
            if (pulse_ms) begin
                ms_count <= '0;
            end else if (pulse_us) begin
                ms_count <= ms_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/usage_counter.sv
`timescale 1ns/1ns
`default_nettype none

module usage_counter (
    input  logic                            sysclk,
    input  logic                            rst,
    input  logic                            poll,
    input  logic                            window_end,
    input  logic                            clear,
    output logic [io_plane_pkg::DATA_W-1:0] usage
);
    import io_plane_pkg::*;

    // polls seen so far in the current window.
    logic [DATA_W-1:0] running;

    always_ff @(posedge sysclk) begin
        if (rst || clear) begin
            running <= '0;
            usage <= '0;
        end else if (window_end) begin
            // publish the window and start the next one.
            // a poll in the boundary cycle counts toward the new window.
            usage <= running;
            running <= {{(DATA_W - 1){1'b0}}, poll};
        end else if (poll) begin
            running <= running + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the io_plane testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
        --top-module io_plane_tb -Mdir obj_dir -f build.f; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vio_plane_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: testbench/bus_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

module bus_slave_model (
    input  logic        sysclk,
    input  logic        rst,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [15:0] writedata,
    output logic [15:0] readdata,
    output logic        waitrequest
);

    logic [15:0] mem [0:255];
    // wait states still to insert before the current command is taken.
    logic [1:0]  wait_left;
    logic [31:0] draw;
    integer      seed = 32'he7b5ad0f;

    // each word starts as its address over the inverted address.
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
        end
    end

    // only the low address byte selects a word.
    assign readdata = mem[address[7:0]];
    // a zero draw lets the command through in its first cycle.
    assign waitrequest = (read || write) && (wait_left != 2'd0);

    always @(posedge sysclk) begin
        if (rst) begin
            draw = $random(seed);
            wait_left <= draw[1:0];
        end else if (read || write) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                // command accepted, pick the stall for the next one.
                if (write) begin
                    mem[address[7:0]] <= writedata;
                end
                draw = $random(seed);
                wait_left <= draw[1:0];
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/io_plane_tb.sv
`timescale 1ns/1ns
`default_nettype none

module io_plane_tb;
    import io_plane_pkg::*;

    // one row of the stimulus table.
    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_KEYS,
        OP_WAIT_VALUE,
        OP_WAIT_BRIDGE
    } op_t;

    // data is the load value, the key pins, or a timeout in cycles.
    // expected is the read value, or the bus command bits for a bridge wait.
    typedef struct packed {
        op_t         op;
        reg_addr_t   addr;
        logic [31:0] data;
        logic [15:0] expected;
    } entry_t;

    logic        sysclk;
    logic        rst;
    reg_addr_t   reg_addr;
    logic        reg_load;
    logic        reg_read;
    logic [15:0] load_data;
    logic [15:0] read_data;
    logic        mcu_wait;
    logic [1:0]  key;
    logic [7:0]  led;
    logic [3:0]  anmux_ctrl;
    logic [1:0]  scope;
    logic [31:0] m0_address;
    logic        m0_read;
    logic        m0_write;
    logic [15:0] m0_writedata;
    logic [15:0] m0_readdata;
    logic        m0_waitrequest;

    entry_t table_q[$];
    int     errors;
    int     checks;

    io_plane dut (
        .sysclk(sysclk), .rst(rst), .reg_addr(reg_addr), .reg_load(reg_load),
        .reg_read(reg_read), .load_data(load_data), .read_data(read_data),
        .mcu_wait(mcu_wait), .key(key), .led(led), .anmux_ctrl(anmux_ctrl),
        .scope(scope), .m0_address(m0_address), .m0_read(m0_read),
        .m0_write(m0_write), .m0_writedata(m0_writedata),
        .m0_readdata(m0_readdata), .m0_waitrequest(m0_waitrequest)
    );

    bus_slave_model slave (
        .sysclk(sysclk), .rst(rst), .address(m0_address), .read(m0_read),
        .write(m0_write), .writedata(m0_writedata), .readdata(m0_readdata),
        .waitrequest(m0_waitrequest)
    );

    // 100 ns period.
    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    task automatic note_wrong_value(input string msg);
        errors++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    task automatic note_timeout(input string msg);
        errors++;
        $display("timeout: %s", msg);
    endtask

    task automatic add_entry(input op_t op, input reg_addr_t addr,
                             input logic [31:0] data, input logic [15:0] expected);
        entry_t e;
        e.op = op;
        e.addr = addr;
        e.data = data;
        e.expected = expected;
        table_q.push_back(e);
    endtask

    // set the low address, load write data, wait out the bus write.
    task automatic store_to_memory(input logic [15:0] addr, input logic [15:0] data);
        add_entry(OP_WRITE, REG_AV_AD_LO, {16'h0000, addr}, 16'h0000);
        add_entry(OP_WRITE, REG_AV_WRITE_DATA, {16'h0000, data}, 16'h0000);
        add_entry(OP_WAIT_BRIDGE, REG_AV_WRITE_DATA, 32'd20, 16'h0001);
    endtask

    // a read strobe on the write-data register starts the bus read.
    task automatic fetch_from_memory(input logic [15:0] addr, input logic [15:0] expected,
                                     input logic [15:0] held_wdata);
        add_entry(OP_WRITE, REG_AV_AD_LO, {16'h0000, addr}, 16'h0000);
        add_entry(OP_READ, REG_AV_WRITE_DATA, 32'd0, held_wdata);
        add_entry(OP_WAIT_BRIDGE, REG_AV_WRITE_DATA, 32'd20, 16'h0002);
        add_entry(OP_READ, REG_AV_READ_DATA, 32'd0, expected);
    endtask

    // output pins that mirror a register.
    function automatic logic pins_follow(input reg_addr_t addr, input logic [15:0] value);
        case (addr)
            REG_LEDS: return led == value[7:0];
            REG_ANMUX: return anmux_ctrl == value[3:0];
            REG_SOFT_EVENT: return scope == value[14:13];
            default: return 1'b1;
        endcase
    endfunction

    // every entry starts and ends on a falling edge.
    task automatic apply_entry(input entry_t e);
        int cycles;
        cycles = 0;
        case (e.op)
            OP_WRITE: begin
                checks++;
                assert (!mcu_wait) else note_wrong_value("write issued while core stalled");
                reg_addr = e.addr;
                load_data = e.data[15:0];
                reg_load = 1'b1;
                @(negedge sysclk);
                reg_load = 1'b0;
            end
            OP_READ: begin
                checks++;
                assert (!mcu_wait) else note_wrong_value("read issued while core stalled");
                reg_addr = e.addr;
                reg_read = 1'b1;
                #1;
                assert (read_data == e.expected) else note_wrong_value($sformatf(
                    "register %0d read %h, expected %h", e.addr, read_data, e.expected));
                assert (pins_follow(e.addr, e.expected)) else note_wrong_value($sformatf(
                    "pins of register %0d do not follow %h", e.addr, e.expected));
                @(negedge sysclk);
                reg_read = 1'b0;
            end
            OP_KEYS: begin
                key = e.data[1:0];
                @(negedge sysclk);
            end
            OP_WAIT_VALUE: begin
                checks++;
                reg_addr = e.addr;
                #1;
                while (read_data != e.expected && cycles < int'(e.data)) begin
                    @(negedge sysclk);
                    #1;
                    cycles++;
                end
                assert (read_data == e.expected) else note_timeout($sformatf(
                    "register %0d never read %h within %0d cycles", e.addr, e.expected,
                    e.data));
                @(negedge sysclk);
            end
            OP_WAIT_BRIDGE: begin
                checks++;
                #1;
                assert (mcu_wait) else note_wrong_value("bridge did not stall the core");
                // the bus command rises in the cycle after the trigger.
                assert ({m0_read, m0_write} == e.expected[1:0]) else note_wrong_value(
                    $sformatf("bus command read=%b write=%b, expected %b",
                              m0_read, m0_write, e.expected[1:0]));
                while (mcu_wait && cycles < int'(e.data)) begin
                    @(negedge sysclk);
                    #1;
                    cycles++;
                end
                assert (!mcu_wait) else note_timeout($sformatf(
                    "mcu_wait still high after %0d cycles", e.data));
                @(negedge sysclk);
            end
            default: ;
        endcase
    endtask

    initial begin
        errors = 0;
        checks = 0;
        rst = 1'b1;
        reg_addr = REG_LEDS;
        reg_load = 1'b0;
        reg_read = 1'b0;
        load_data = 16'h0000;
        // keys are active low, so both released.
        key = 2'b11;

        // output registers, scope pins and raw keys.
        add_entry(OP_WRITE, REG_LEDS, 32'h12A5, 16'h0000);
        add_entry(OP_READ, REG_LEDS, 32'd0, 16'h00A5);
        add_entry(OP_WRITE, REG_ANMUX, 32'hFFF9, 16'h0000);
        add_entry(OP_READ, REG_ANMUX, 32'd0, 16'h0009);
        add_entry(OP_WRITE, REG_SOFT_EVENT, 32'h6000, 16'h0000);
        add_entry(OP_READ, REG_SOFT_EVENT, 32'd0, 16'h6000);
        add_entry(OP_WRITE, REG_SOFT_EVENT, 32'h2000, 16'h0000);
        add_entry(OP_READ, REG_SOFT_EVENT, 32'd0, 16'h2000);
        add_entry(OP_READ, REG_KEYS, 32'd0, 16'h0003);
        add_entry(OP_KEYS, REG_KEYS, 32'd1, 16'h0000);
        add_entry(OP_READ, REG_KEYS, 32'd0, 16'h0001);
        add_entry(OP_KEYS, REG_KEYS, 32'd3, 16'h0000);

        // key and soft lines, then the soft reset of the mask.
        add_entry(OP_READ, REG_EVENT_PRIORITY, 32'd0, 16'hFFFF);
        add_entry(OP_WRITE, REG_EVENT_PRIORITY, 32'h01F8, 16'h0000);
        add_entry(OP_KEYS, REG_KEYS, 32'd2, 16'h0000);
        add_entry(OP_READ, REG_EVENT_PRIORITY, 32'd0, 16'h0003);
        add_entry(OP_WRITE, REG_SOFT_EVENT, 32'h0001, 16'h0000);
        add_entry(OP_READ, REG_EVENT_PRIORITY, 32'd0, 16'h0003);
        add_entry(OP_KEYS, REG_KEYS, 32'd3, 16'h0000);
        add_entry(OP_READ, REG_EVENT_PRIORITY, 32'd0, 16'h0005);
        add_entry(OP_WRITE, REG_SOFT_EVENT, 32'h8001, 16'h0000);
        // the mask clears only once the soft-reset bit sits in its register.
        add_entry(OP_WAIT_VALUE, REG_EVENT_PRIORITY, 32'd4, 16'hFFFF);
        add_entry(OP_WRITE, REG_SOFT_EVENT, 32'h0000, 16'h0000);
        add_entry(OP_READ, REG_EVENT_PRIORITY, 32'd0, 16'hFFFF);

        // timers. the ms timer expiry also lines up with a window end.
        add_entry(OP_WRITE, REG_USTIMER0, 32'd5, 16'h0000);
        add_entry(OP_WRITE, REG_EVENT_PRIORITY, 32'h0001, 16'h0000);
        add_entry(OP_READ, REG_EVENT_PRIORITY, 32'd0, 16'hFFFF);
        add_entry(OP_WAIT_VALUE, REG_EVENT_PRIORITY, 32'd400, 16'h0000);
        add_entry(OP_WRITE, REG_MSTIMER0, 32'd1, 16'h0000);
        add_entry(OP_WAIT_VALUE, REG_MSTIMER0, 32'd100000, 16'h0000);

        // seven polls in a fresh window.
        add_entry(OP_WRITE, REG_USAGE, 32'd0, 16'h0000);
        add_entry(OP_READ, REG_USAGE, 32'd0, 16'h0000);
        repeat (7) add_entry(OP_READ, REG_EVENT_PRIORITY, 32'd0, 16'h0000);
        add_entry(OP_WAIT_VALUE, REG_USAGE, 32'd60000, 16'h0007);
        add_entry(OP_WRITE, REG_USAGE, 32'h1234, 16'h0000);
        add_entry(OP_READ, REG_USAGE, 32'd0, 16'h0000);

        // bus writes, then reads back including an untouched word.
        add_entry(OP_WRITE, REG_AV_AD_HI, 32'd0, 16'h0000);
        store_to_memory(16'h0003, 16'hBEEF);
        store_to_memory(16'h0080, 16'h1234);
        store_to_memory(16'h00FF, 16'hA55A);
        fetch_from_memory(16'h0003, 16'hBEEF, 16'hA55A);
        fetch_from_memory(16'h0080, 16'h1234, 16'hA55A);
        fetch_from_memory(16'h00FF, 16'hA55A, 16'hA55A);
        fetch_from_memory(16'h0042, 16'h42BD, 16'hA55A);

        repeat (2) @(negedge sysclk);
        rst = 1'b0;
        checks++;
        assert (!m0_read && !m0_write && !mcu_wait && led == 8'h00 && anmux_ctrl == 4'h0
                && scope == 2'b00) else note_wrong_value("outputs not cleared by reset");

        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
